// File: src.f
source/lsu_cfg_pkg.sv
source/lsu_types_pkg.sv
source/lsu_decode.sv
source/lsu_bypass.sv
source/lsu_mem_access.sv
source/lsu_result_reg.sv
source/load_store_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_load_store_unit.sv

// File: testbench/tb_load_store_unit.sv
// load-store unit testbench with wishbone memory model, reference model and result checker
`timescale 1ns/10ps
`default_nettype none

module tb_load_store_unit import lsu_cfg_pkg::*, lsu_types_pkg::*; ();

    localparam int N_OPS          = 400;
    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = N_OPS * 8 + 100;

    typedef struct packed {
        logic          is_store;
        logic          bus;
        load_result_t  ld;
        store_result_t st;
    } expect_t;

    logic          clk;
    logic          rst_n;
    fu_data_t      fu_data;
    logic          lsu_valid;
    logic          lsu_ready;
    wb_req_t       wb_req;
    wb_rsp_t       wb_rsp;
    load_result_t  load_res;
    store_result_t store_res;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    expect_t     exp_q [$];
    int          mismatch_count = 0;
    int          other_count    = 0;
    int          bus_cycles     = 0;
    int          exp_bus_cycles = 0;
    int          issued         = 0;
    int          cycle_count    = 0;
    logic [TRANS_ID_BITS-1:0] next_id = '0;

    tb_clock_gen i_clock_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    load_store_unit uut (
        .clk_i       ( clk       ),
        .rst_ni      ( rst_n     ),
        .fu_data_i   ( fu_data   ),
        .lsu_valid_i ( lsu_valid ),
        .lsu_ready_o ( lsu_ready ),
        .wb_req_o    ( wb_req    ),
        .wb_rsp_i    ( wb_rsp    ),
        .load_o      ( load_res  ),
        .store_o     ( store_res )
    );

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h0104_1041) ^ 32'hc3a5_5a3c;
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic expect_t predict(input fu_data_t op);
        expect_t     e;
        exception_t  ex;
        logic [31:0] addr;
        logic [31:0] value;
        logic        store;
        int          nbytes;
        int          word;
        int          off;
        e      = '0;
        ex     = '0;
        value  = '0;
        addr   = op.base + op.imm;
        store  = (op.op == SB) || (op.op == SH) || (op.op == SW);
        nbytes = (op.op inside {LB, LBU, SB}) ? 1 : (op.op inside {LH, LHU, SH}) ? 2 : 4;
        word   = int'(addr[31:2]);
        off    = int'(addr[1:0]);
        if ((addr % nbytes) != 0) begin
            ex = '{valid: 1'b1, cause: store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED,
                   tval: addr};
        end else if (addr >= MEM_WORDS * 4) begin
            e.bus = 1'b1;
            ex = '{valid: 1'b1, cause: store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT,
                   tval: addr};
        end else begin
            e.bus = 1'b1;
            for (int i = 0; i < nbytes; i++) begin
                if (store) begin
                    shadow[word][8*(off+i) +: 8] = op.store_data[8*i +: 8];
                end else begin
                    value[8*i +: 8] = shadow[word][8*(off+i) +: 8];
                end
            end
            if (op.op == LB) begin
                value[31:8] = {24{value[7]}};
            end else if (op.op == LH) begin
                value[31:16] = {16{value[15]}};
            end
        end
        e.is_store    = store;
        e.ld          = '{valid: !store, trans_id: op.trans_id, data: value, ex: ex};
        e.st          = '{valid: store, trans_id: op.trans_id, ex: ex};
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic match_result(input logic got_store, input logic [31:0] tid,
                                input logic [31:0] data, input exception_t ex);
        expect_t    e;
        exception_t exp_ex;
        string      port;
        port = got_store ? "store_o" : "load_o";
        if (exp_q.size() == 0) begin
            other_count++;
            $display("ERROR: a %s result arrived with no operation pending",
                     got_store ? "store" : "load");
        end else begin
            e = exp_q.pop_front();
            exp_ex = got_store ? e.st.ex : e.ld.ex;
            if (e.is_store != got_store) begin
                other_count++;
                $display("ERROR: results left out of issue order at cycle %0d", cycle_count);
            end else if (got_store) begin
                check_value("store_o.trans_id", tid, 32'(e.st.trans_id));
            end else begin
                check_value("load_o.trans_id", tid, 32'(e.ld.trans_id));
                check_value("load_o.data", data, e.ld.data);
            end
            check_value({port, ".ex.valid"}, 32'(ex.valid), 32'(exp_ex.valid));
            check_value({port, ".ex.cause"}, ex.cause, exp_ex.cause);
            check_value({port, ".ex.tval"}, ex.tval, exp_ex.tval);
        end
    endtask

    // called and returning 1 ns after a rising edge
    task automatic issue_op(input lsu_op_e op, input logic [31:0] base,
                            input logic [31:0] imm, input logic [31:0] data);
        fu_data_t f;
        expect_t  e;
        f = '{op: op, base: base, imm: imm, store_data: data, trans_id: next_id};
        while (!lsu_ready) begin
            @(posedge clk);
            #1;
        end
        fu_data   = f;
        lsu_valid = 1'b1;
        e = predict(f);
        exp_q.push_back(e);
        exp_bus_cycles += e.bus;
        @(posedge clk);
        #1;
        lsu_valid = 1'b0;
        next_id++;
        issued++;
    endtask

    // ----------------------------------------
    // wishbone slave memory
    // ----------------------------------------
    initial begin : wb_slave
        int   waits;
        logic busy;
        int   idx;
        wb_rsp = '0;
        busy   = 1'b0;
        waits  = 0;
        forever begin
            @(posedge clk);
            #1;
            idx = int'(wb_req.adr[7:2]);
            if (wb_rsp.ack || wb_rsp.err) begin
                wb_rsp = '0;
                busy   = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = $urandom_range(0, 3);
                    bus_cycles++;
                end
                if (waits > 0) begin
                    waits--;
                end else if (wb_req.adr >= MEM_WORDS * 4) begin
                    wb_rsp.err = 1'b1;
                end else begin
                    wb_rsp.ack = 1'b1;
                    wb_rsp.dat = mem[idx];
                    for (int b = 0; b < BE_WIDTH; b++) begin
                        if (wb_req.we && wb_req.sel[b]) begin
                            mem[idx][8*b +: 8] = wb_req.dat[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // results sampled mid-cycle
    always @(negedge clk) begin
        if (load_res.valid) begin
            match_result(1'b0, 32'(load_res.trans_id), load_res.data, load_res.ex);
        end
        if (store_res.valid) begin
            match_result(1'b1, 32'(store_res.trans_id), '0, store_res.ex);
        end
        if (wb_req.cyc && lsu_ready) begin
            other_count++;
            $display("ERROR: lsu_ready_o high while a bus cycle is open");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : main
        lsu_op_e     stores [3];
        lsu_op_e     loads [5];
        logic [31:0] addr;
        logic [31:0] imm;
        int          off;
        stores    = '{SW, SH, SB};
        loads     = '{LW, LH, LHU, LB, LBU};
        fu_data   = '0;
        lsu_valid = 1'b0;
        void'($urandom(32'he622_591b));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end

        // idle after reset
        @(posedge rst_n);
        repeat (3) begin
            @(negedge clk);
            if (!lsu_ready || load_res.valid || store_res.valid) begin
                other_count++;
                $display("ERROR: unit not idle after reset");
            end
        end
        @(posedge clk);
        #1;

        // store then load back at the same address
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 5; l++) begin
                if (stores[s] == SW || loads[l] == LW) begin
                    off = 0;
                end else if (stores[s] == SH || loads[l] inside {LH, LHU}) begin
                    off = 2;
                end else begin
                    off = 3;
                end
                addr = 32'((s * 5 + l) * 4 + off);
                imm  = 32'(l) - 32'd2;
                issue_op(stores[s], addr - imm, imm, $urandom());
                issue_op(loads[l], addr - imm, imm, $urandom());
            end
        end

        // misaligned accesses without a bus cycle
        issue_op(LH, 32'h10, 32'h1, '0);
        issue_op(LW, 32'h20, 32'h2, '0);
        issue_op(SH, 32'h30, 32'h3, 32'hdead_beef);
        issue_op(SW, 32'h41, 32'h0, 32'h1234_5678);
        issue_op(LHU, 32'h0, 32'h5, '0);

        // beyond the memory
        issue_op(LW, 32'h100, 32'h0, '0);
        issue_op(SW, 32'h1fc, 32'h4, 32'hffff_ffff);
        issue_op(LBU, 32'h3ff, 32'h0, '0);
        issue_op(SH, 32'h1000_0000, 32'h2, 32'h0000_abcd);
        issue_op(LH, 32'h0, 32'hffff_fffe, '0);

        while (issued < N_OPS) begin
            issue_op(lsu_op_e'($urandom_range(0, 7)), 32'($urandom_range(0, 287)),
                     32'($urandom_range(0, 20)) - 32'd4, $urandom());
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);

        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("mem[%0d]", i), mem[i], shadow[i]);
        end
        check_value("bus cycle count", 32'(bus_cycles), 32'(exp_bus_cycles));

        $display("%0d operations, %0d mismatches, %0d other errors",
                 issued, mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// testbench clock and reset source: 10 ns clock, active low reset held for 10 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // release just after an edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
// load-store unit top: decode, execute and result stages
`timescale 1ns/10ps
`default_nettype none

module load_store_unit import lsu_cfg_pkg::*, lsu_types_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire fu_data_t fu_data_i,
    input  wire logic     lsu_valid_i,
    output logic          lsu_ready_o,
    output wb_req_t       wb_req_o,
    input  wire wb_rsp_t  wb_rsp_i,
    output load_result_t  load_o,
    output store_result_t store_o
);

    lsu_ctrl_t     dec_ctrl;
    lsu_ctrl_t     exe_ctrl;
    logic          pop;
    load_result_t  ld_res;
    store_result_t st_res;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    lsu_decode i_decode (
        .fu_data_i ( fu_data_i   ),
        .valid_i   ( lsu_valid_i ),
        .ctrl_o    ( dec_ctrl    )
    );

    // ----------------------------------------
    // execute
    // ----------------------------------------
    lsu_bypass i_bypass (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .req_i       ( dec_ctrl    ),
        .req_valid_i ( lsu_valid_i ),
        .pop_i       ( pop         ),
        .ctrl_o      ( exe_ctrl    ),
        .ready_o     ( lsu_ready_o )
    );

    lsu_mem_access i_mem_access (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .ctrl_i   ( exe_ctrl ),
        .pop_o    ( pop      ),
        .wb_req_o ( wb_req_o ),
        .wb_rsp_i ( wb_rsp_i ),
        .load_o   ( ld_res   ),
        .store_o  ( st_res   )
    );

    // ----------------------------------------
    // result
    // ----------------------------------------
    lsu_result_reg #(
        .payload_t ( load_result_t   ),
        .DEPTH     ( LOAD_PIPE_DEPTH )
    ) i_load_reg (
        .clk_i  ( clk_i  ),
        .rst_ni ( rst_ni ),
        .d_i    ( ld_res ),
        .d_o    ( load_o )
    );

    lsu_result_reg #(
        .payload_t ( store_result_t   ),
        .DEPTH     ( STORE_PIPE_DEPTH )
    ) i_store_reg (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .d_i    ( st_res  ),
        .d_o    ( store_o )
    );

endmodule

`default_nettype wire

// File: source/lsu_result_reg.sv
// lsu result pipeline: shift chain of registers for any result payload
`timescale 1ns/10ps
`default_nettype none

module lsu_result_reg #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 1
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire payload_t d_i,
    output payload_t      d_o
);

    if (DEPTH == 0) begin : gen_pass
        assign d_o = d_i;
    end else begin : gen_chain
        payload_t chain_q [DEPTH];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < DEPTH; i++) begin
                    chain_q[i] <= '0;
                end
            end else begin
                chain_q[0] <= d_i;
                for (int i = 1; i < DEPTH; i++) begin
                    chain_q[i] <= chain_q[i-1];
                end
            end
        end

        assign d_o = chain_q[DEPTH-1];
    end

endmodule

`default_nettype wire

// File: source/lsu_mem_access.sv
// lsu memory access engine: wishbone classic master for loads and stores
`timescale 1ns/10ps
`default_nettype none

module lsu_mem_access import lsu_cfg_pkg::*, lsu_types_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire lsu_ctrl_t ctrl_i,
    output logic           pop_o,
    output wb_req_t        wb_req_o,
    input  wire wb_rsp_t   wb_rsp_i,
    output load_result_t   load_o,
    output store_result_t  store_o
);

    typedef enum logic {
        ST_IDLE,
        ST_BUS
    } state_e;

    state_e          state_q, state_d;
    wb_req_t         req_q, req_d;
    load_result_t    load_q, load_d;
    store_result_t   store_q, store_d;
    logic            is_store;
    logic            bus_done;
    logic [4:0]      shamt;
    logic [XLEN-1:0] rdata_shift;
    logic [XLEN-1:0] rdata_ext;

    assign is_store = ctrl_i.op inside {SB, SH, SW};
    assign bus_done = wb_rsp_i.ack || wb_rsp_i.err;
    assign shamt    = {ctrl_i.offset, 3'b000};

    // ----------------------------------------
    // load data alignment and extension
    // ----------------------------------------
    assign rdata_shift = wb_rsp_i.dat >> shamt;

    always_comb begin
        case (ctrl_i.op)
            LB:      rdata_ext = {{(XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
            LBU:     rdata_ext = {{(XLEN-8){1'b0}}, rdata_shift[7:0]};
            LH:      rdata_ext = {{(XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
            LHU:     rdata_ext = {{(XLEN-16){1'b0}}, rdata_shift[15:0]};
            default: rdata_ext = rdata_shift;
        endcase
    end

    // ----------------------------------------
    // engine
    // ----------------------------------------
    always_comb begin
        state_d          = state_q;
        req_d            = req_q;
        pop_o            = 1'b0;
        load_d           = '0;
        load_d.trans_id  = ctrl_i.trans_id;
        store_d          = '0;
        store_d.trans_id = ctrl_i.trans_id;

        case (state_q)
            ST_IDLE: begin
                if (ctrl_i.valid && ctrl_i.ex.valid) begin
                    // misaligned, retire without touching the bus
                    pop_o         = 1'b1;
                    load_d.valid  = !is_store;
                    load_d.ex     = ctrl_i.ex;
                    store_d.valid = is_store;
                    store_d.ex    = ctrl_i.ex;
                end else if (ctrl_i.valid) begin
                    req_d.cyc = 1'b1;
                    req_d.stb = 1'b1;
                    req_d.we  = is_store;
                    req_d.adr = ctrl_i.addr;
                    req_d.sel = ctrl_i.be;
                    req_d.dat = ctrl_i.data << shamt;
                    state_d   = ST_BUS;
                end
            end
            default: begin
                if (bus_done) begin
                    pop_o         = 1'b1;
                    req_d.cyc     = 1'b0;
                    req_d.stb     = 1'b0;
                    state_d       = ST_IDLE;
                    load_d.valid  = !is_store;
                    store_d.valid = is_store;
                    if (wb_rsp_i.err) begin
                        load_d.ex.valid  = 1'b1;
                        load_d.ex.cause  = CAUSE_LD_ACCESS_FAULT;
                        load_d.ex.tval   = {ctrl_i.addr[XLEN-1:2], ctrl_i.offset};
                        store_d.ex.valid = 1'b1;
                        store_d.ex.cause = CAUSE_ST_ACCESS_FAULT;
                        store_d.ex.tval  = {ctrl_i.addr[XLEN-1:2], ctrl_i.offset};
                    end else begin
                        load_d.data = rdata_ext;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            req_q   <= '0;
            load_q  <= '0;
            store_q <= '0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
            load_q  <= load_d;
            store_q <= store_d;
        end
    end

    assign wb_req_o = req_q;
    assign load_o   = load_q;
    assign store_o  = store_q;

    stb_has_cyc_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_req_o.stb |-> wb_req_o.cyc
    ) else $error("stb without cyc");

    // request held until the slave answers
    req_stable_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err |=> wb_req_o.stb && $stable(wb_req_o)
    ) else $error("wishbone request changed during wait state");

endmodule

`default_nettype wire

// File: source/lsu_bypass.sv
// lsu bypass buffer: two entries that hold the current operation while the bus is busy
`timescale 1ns/10ps
`default_nettype none

module lsu_bypass import lsu_types_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire lsu_ctrl_t req_i,
    input  wire logic      req_valid_i,
    input  wire logic      pop_i,
    output lsu_ctrl_t      ctrl_o,
    output logic           ready_o
);

    lsu_ctrl_t  mem_q [2];
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] count_q;
    logic       empty;
    logic       push;

    assign empty   = (count_q == 2'd0);
    assign ready_o = empty;
    assign push    = req_valid_i && ready_o;

    // incoming operation goes straight through when nothing is held
    assign ctrl_o = empty ? req_i : mem_q[rd_ptr_q];

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop_i) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop_i})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
        // a retired head is no longer valid
        if (pop_i) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

    push_not_full_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push |-> count_q != 2'd2
    ) else $error("push into full bypass buffer");

    // the engine may only retire an operation it has been shown
    pop_not_empty_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> (count_q != 2'd0) || push
    ) else $error("pop from empty bypass buffer");

endmodule

`default_nettype wire

// File: source/lsu_decode.sv
// lsu decode stage for address generation, transfer size, byte enables and alignment check
`timescale 1ns/10ps
`default_nettype none

module lsu_decode import lsu_cfg_pkg::*, lsu_types_pkg::*; (
    input  wire fu_data_t  fu_data_i,
    input  wire logic      valid_i,
    output lsu_ctrl_t      ctrl_o
);

    logic [XLEN-1:0]     vaddr;
    logic [1:0]          size;
    logic [1:0]          offset;
    logic [BE_WIDTH-1:0] be;
    logic                misaligned;
    logic                is_store;

    // base plus immediate
    assign vaddr    = fu_data_i.base + fu_data_i.imm;
    assign offset   = vaddr[1:0];
    assign is_store = fu_data_i.op inside {SB, SH, SW};

    // transfer size as log2 of the byte count
    always_comb begin
        unique case (fu_data_i.op)
            LB, LBU, SB: size = 2'd0;
            LH, LHU, SH: size = 2'd1;
            default:     size = 2'd2;
        endcase
    end

    always_comb begin
        be         = 4'b1111;
        misaligned = 1'b0;
        case (size)
            2'd0: be = 4'b0001 << offset;
            2'd1: begin
                be         = 4'b0011 << offset;
                misaligned = offset[0];
            end
            default: misaligned = (offset != 2'b00);
        endcase
    end

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.valid    = valid_i;
        ctrl_o.addr     = {vaddr[XLEN-1:2], 2'b00};
        ctrl_o.offset   = offset;
        ctrl_o.be       = be;
        ctrl_o.op       = fu_data_i.op;
        ctrl_o.data     = fu_data_i.store_data;
        ctrl_o.trans_id = fu_data_i.trans_id;
        // misalignment known before any bus cycle
        if (valid_i && misaligned) begin
            ctrl_o.ex.valid = 1'b1;
            ctrl_o.ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            ctrl_o.ex.tval  = vaddr;
        end
    end

    // byte accesses fit any offset
    always_comb begin
        if (valid_i && (fu_data_i.op inside {LB, LBU, SB})) begin
            byte_aligned_a: assert final (!ctrl_o.ex.valid)
                else $error("byte operator flagged misaligned");
        end
    end

endmodule

`default_nettype wire

// File: source/lsu_types_pkg.sv
// load-store unit types: operator codes and the structs passed between stages
`default_nettype none

package lsu_types_pkg;

    import lsu_cfg_pkg::*;

    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    // operation as issued
    typedef struct packed {
        lsu_op_e                  op;
        logic [XLEN-1:0]          base;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          store_data;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        // faulting byte address
        logic [XLEN-1:0] tval;
    } exception_t;

    // ----------------------------------------
    // decoded operation
    // ----------------------------------------
    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          addr;
        logic [1:0]               offset;
        logic [BE_WIDTH-1:0]      be;
        lsu_op_e                  op;
        logic [XLEN-1:0]          data;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } lsu_ctrl_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
        exception_t               ex;
    } load_result_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } store_result_t;

    // ----------------------------------------
    // wishbone classic
    // ----------------------------------------
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [XLEN-1:0]     adr;
        logic [BE_WIDTH-1:0] sel;
        logic [XLEN-1:0]     dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic            err;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: source/lsu_cfg_pkg.sv
// load-store unit configuration: widths, pipe depths and exception cause codes
`default_nettype none

package lsu_cfg_pkg;

    // data path and bus
    localparam int unsigned XLEN          = 32;
    localparam int unsigned BE_WIDTH      = 4;
    localparam int unsigned TRANS_ID_BITS = 3;

    // output pipeline registers, set independently per result kind
    localparam int unsigned LOAD_PIPE_DEPTH  = 1;
    localparam int unsigned STORE_PIPE_DEPTH = 1;

    // ----------------------------------------
    // exception causes
    // ----------------------------------------
    localparam logic [XLEN-1:0] CAUSE_LD_MISALIGNED   = 4;
    localparam logic [XLEN-1:0] CAUSE_LD_ACCESS_FAULT = 5;
    localparam logic [XLEN-1:0] CAUSE_ST_MISALIGNED   = 6;
    localparam logic [XLEN-1:0] CAUSE_ST_ACCESS_FAULT = 7;

endpackage

`default_nettype wire
